// File: bg_fetcher/bg_fetcher.sv
`timescale 1ns/1ps

// background tile fetcher and pixel output
module bg_fetcher import video_pkg::*; (
	input  logic clk_reg,
	input  logic reset,
	lcd_timing_if.consumer tim,
	lcd_regs_if.user regs,
	input  lcd_mode_e mode,
	output logic vram_rd,
	output logic [12:0] vram_addr,
	input  logic [7:0] vram_data,
	output logic lcd_clkena,
	output logic [1:0] lcd_data
);

	// cycle count inside draw, 0..175
	logic [7:0] fcnt;
	// scroll values held for the whole line
	logic [7:0] scx_r;
	logic [7:0] scy_r;
	// fetched tile index and bit planes
	logic [7:0] tile_idx;
	logic [7:0] data_lo;
	logic [7:0] data_hi;
	// pixel shifters, msb leaves first
	logic [7:0] shift_lo;
	logic [7:0] shift_hi;

	wire draw_act = (mode == MODE_DRAW);
	// 8 cycle tile step made of four 2 cycle slots
	wire [4:0] tile_cnt = fcnt[7:3];
	wire [1:0] slot = fcnt[2:1];
	wire fetch_on = draw_act && (tile_cnt < FETCH_TILES);

	// ----------------------------------------------------------
	// vram addressing
	// ----------------------------------------------------------

	// background row seen on this screen line
	wire [7:0] bg_line = tim.v_cnt + scy_r;
	// map column wraps at 32 tiles
	wire [4:0] map_col = scx_r[7:3] + tile_cnt;
	wire [12:0] map_base = regs.lcdc[3] ? MAP1_BASE : MAP0_BASE;
	wire [12:0] map_addr = map_base + {3'b000, bg_line[7:3], map_col};
	// signed layout around 1000h when lcdc bit 4 is clear
	wire tile_a12 = regs.lcdc[4] ? 1'b0 : ~tile_idx[7];
	wire [11:0] row_addr = {tile_a12, tile_idx, bg_line[2:0]};

	always_comb begin
		case (slot)
			2'd0:    vram_addr = map_addr;
			2'd1:    vram_addr = {row_addr, 1'b0};
			default: vram_addr = {row_addr, 1'b1};
		endcase
	end

	// slot 3 loads the shifters and needs no memory
	assign vram_rd = fetch_on && (slot != 2'd3);

	// ----------------------------------------------------------
	// sequencing
	// ----------------------------------------------------------
	always_ff @(posedge clk_reg) begin
		if (reset)
			fcnt <= '0;
		else if (draw_act)
			fcnt <= fcnt + 8'd1;
		else
			fcnt <= '0;
	end

	// latch scroll shortly before draw starts
	always_ff @(posedge clk_reg) begin
		if (tim.h_cnt == SCROLL_LATCH_CYCLE) begin
			scx_r <= regs.scx;
			scy_r <= regs.scy;
		end
	end

	// memory answers one cycle late, so sample in the second slot cycle
	always_ff @(posedge clk_reg) begin
		if (fetch_on && fcnt[0]) begin
			case (slot)
				2'd0:    tile_idx <= vram_data;
				2'd1:    data_lo <= vram_data;
				2'd2:    data_hi <= vram_data;
				default: ;
			endcase
		end
	end

	// reload exactly when the previous tile has shifted out
	always_ff @(posedge clk_reg) begin
		if (fetch_on && (fcnt[2:0] == 3'd7)) begin
			shift_lo <= data_lo;
			shift_hi <= data_hi;
		end else begin
			shift_lo <= {shift_lo[6:0], 1'b0};
			shift_hi <= {shift_hi[6:0], 1'b0};
		end
	end

	// ----------------------------------------------------------
	// pixel output
	// ----------------------------------------------------------

	// pixels of the first tile leave from cycle 8, fine scroll drops the first few
	wire [7:0] first_pix = 8'd8 + {5'd0, scx_r[2:0]};
	wire emit = draw_act && (fcnt >= first_pix) && (fcnt < first_pix + SCREEN_WIDTH);
	wire [1:0] colour = {shift_hi[7], shift_lo[7]};
	// background disabled gives the lightest shade
	wire [1:0] shade = regs.lcdc[0] ? regs.bgp[{colour, 1'b0} +: 2] : 2'b00;

	always_ff @(posedge clk_reg) begin
		if (reset)
			lcd_clkena <= 1'b0;
		else
			lcd_clkena <= emit;
	end

	always_ff @(posedge clk_reg) begin
		lcd_data <= shade;
	end

endmodule

// File: common/lcd_regs_if.sv
`timescale 1ns/1ps

// control register values fanned out from the register file
interface lcd_regs_if;

	// display control
	logic [7:0] lcdc;
	// interrupt enables in bits 6..3
	logic [7:0] stat;
	// background scroll
	logic [7:0] scx;
	logic [7:0] scy;
	// line compare value
	logic [7:0] lyc;
	// background palette
	logic [7:0] bgp;
	// single cycle strobe after a LYC write
	logic lyc_written;

	modport regs (
		output lcdc, output stat, output scx, output scy,
		output lyc, output bgp, output lyc_written
	);

	modport user (
		input lcdc, input stat, input scx, input scy,
		input lyc, input bgp, input lyc_written
	);

endinterface

// File: common/lcd_timing_if.sv
`timescale 1ns/1ps

// line and frame counters shared by all timing consumers
interface lcd_timing_if;

	// cycle within the line, 0..455
	logic [8:0] h_cnt;
	// line within the frame, doubles as LY
	logic [7:0] v_cnt;
	// last cycle of a line
	logic line_end;
	// last cycle of the last line
	logic frame_end;

	modport timer (output h_cnt, output v_cnt, output line_end, output frame_end);

	modport consumer (input h_cnt, input v_cnt, input line_end, input frame_end);

endinterface

// File: common/video_pkg.sv
// shared constants and types for the background video path
package video_pkg;

	// ----------------------------------------------------------
	// line and frame timing
	// ----------------------------------------------------------

	// cycles in one line, counter runs 0..455
	localparam logic [8:0] LINE_CYCLES = 9'd456;
	// lines in one frame, including vblank
	localparam logic [7:0] FRAME_LINES = 8'd154;
	// lines that carry pixels
	localparam logic [7:0] VISIBLE_LINES = 8'd144;
	// pixels per visible line
	localparam logic [7:0] SCREEN_WIDTH = 8'd160;
	// oam search at the start of each visible line
	localparam logic [8:0] OAM_CYCLES = 9'd80;
	// fixed draw length, no extra stretch for scrolling
	localparam logic [8:0] DRAW_CYCLES = 9'd176;
	// scroll registers get sampled here, just before draw
	localparam logic [8:0] SCROLL_LATCH_CYCLE = 9'd78;
	// one tile more than the screen width covers fine scroll
	localparam logic [4:0] FETCH_TILES = 5'd21;

	// ----------------------------------------------------------
	// vram layout, word offsets inside the 8 KB video ram
	// ----------------------------------------------------------
	localparam logic [12:0] MAP0_BASE = 13'h1800;
	localparam logic [12:0] MAP1_BASE = 13'h1C00;

	// lcd modes, values match the two low bits of STAT
	typedef enum logic [1:0] {
		MODE_HBLANK = 2'd0,
		MODE_VBLANK = 2'd1,
		MODE_OAM    = 2'd2,
		MODE_DRAW   = 2'd3
	} lcd_mode_e;

	// cpu register offsets in the ff00 page
	typedef enum logic [7:0] {
		REG_LCDC = 8'h40,
		REG_STAT = 8'h41,
		REG_SCY  = 8'h42,
		REG_SCX  = 8'h43,
		REG_LY   = 8'h44,
		REG_LYC  = 8'h45,
		REG_BGP  = 8'h47
	} reg_addr_e;

endpackage

// File: run.sh
#!/bin/sh
# build the testbench with verilator, run it, then look for the pass line in the log
verilator --binary --timing --assert -Wno-fatal -f video.f --top-module video_tb \
	-o video_sim > build.log 2>&1 \
	&& ./obj_dir/video_sim > sim.log 2>&1 \
	|| { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "Simulation PASSED" sim.log \
	&& echo "test passed" \
	|| { echo "test failed, see sim.log"; exit 1; }

// File: src/lcd_mode_fsm.sv
`timescale 1ns/1ps

// lcd mode sequencing and STAT / vblank interrupt generation
module lcd_mode_fsm import video_pkg::*; (
	input  logic clk_reg,
	input  logic reset,
	input  logic lcd_on,
	lcd_timing_if.consumer tim,
	lcd_regs_if.user regs,
	output lcd_mode_e mode,
	output logic irq,
	output logic vblank_irq
);

	lcd_mode_e next_mode;

	// high in cycle 0 of line 0, after a frame wrap
	logic frame_wrap;

	// LY against LYC
	wire lyc_match = (tim.v_cnt == regs.lyc);

	// ----------------------------------------------------------
	// mode state machine
	// ----------------------------------------------------------

	// mode lands one cycle after the counter milestone
	always_comb begin
		next_mode = mode;
		if (!lcd_on) begin
			next_mode = MODE_HBLANK;
		end else begin
			case (mode)
				MODE_HBLANK: begin
					// new line starts with oam search or with vblank
					if (tim.h_cnt == 9'd0)
						next_mode = (tim.v_cnt < VISIBLE_LINES) ? MODE_OAM : MODE_VBLANK;
				end
				MODE_OAM: begin
					if (tim.h_cnt == OAM_CYCLES)
						next_mode = MODE_DRAW;
				end
				MODE_DRAW: begin
					// fixed draw length
					if (tim.h_cnt == OAM_CYCLES + DRAW_CYCLES)
						next_mode = MODE_HBLANK;
				end
				MODE_VBLANK: begin
					// leave vblank only when line 0 begins
					if (frame_wrap)
						next_mode = MODE_OAM;
				end
				default: next_mode = MODE_HBLANK;
			endcase
		end
	end

	always_ff @(posedge clk_reg) begin
		if (reset) begin
			mode       <= MODE_HBLANK;
			frame_wrap <= 1'b0;
		end else begin
			mode       <= next_mode;
			frame_wrap <= tim.frame_end;
		end
	end

	// ----------------------------------------------------------
	// interrupts
	// ----------------------------------------------------------

	// compare hit at line start, or a LYC write that matches the current line
	wire lyc_hit = regs.stat[6] && lyc_match && ((tim.h_cnt == 9'd0) || regs.lyc_written);
	// mode entry sources
	wire oam_hit = regs.stat[5] && (next_mode == MODE_OAM) && (mode != MODE_OAM);
	wire vbl_hit = regs.stat[4] && (next_mode == MODE_VBLANK) && (mode != MODE_VBLANK);
	// hblank entry only counts when coming out of draw
	wire hbl_hit = regs.stat[3] && (next_mode == MODE_HBLANK) && (mode == MODE_DRAW);

	always_ff @(posedge clk_reg) begin
		if (reset) begin
			irq        <= 1'b0;
			vblank_irq <= 1'b0;
		end else begin
			// sources in back to back cycles merge into one pulse
			irq <= lcd_on && !irq && (lyc_hit || oam_hit || vbl_hit || hbl_hit);
			// end of the last visible line, once per frame
			vblank_irq <= tim.line_end && (tim.v_cnt == VISIBLE_LINES - 8'd1);
		end
	end

endmodule

// File: src/lcd_regs.sv
`timescale 1ns/1ps

// cpu visible lcd registers
module lcd_regs import video_pkg::*; (
	input  logic clk_reg,
	input  logic reset,
	input  logic cpu_sel,
	input  logic [7:0] cpu_addr,
	input  logic cpu_wr,
	input  logic [7:0] cpu_di,
	output logic [7:0] cpu_do,
	lcd_timing_if.consumer tim,
	input  lcd_mode_e mode,
	lcd_regs_if.regs regs,
	output logic lcd_on
);

	logic [7:0] lcdc;
	logic [7:0] stat;
	logic [7:0] scy;
	logic [7:0] scx;
	logic [7:0] lyc;
	logic [7:0] bgp;
	logic lyc_written;

	// decoded register offset
	reg_addr_e addr;

	assign addr = reg_addr_e'(cpu_addr);

	// LY equals LYC, reported in STAT bit 2
	wire lyc_match = (tim.v_cnt == lyc);

	// ----------------------------------------------------------
	// write side
	// ----------------------------------------------------------
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			// display comes up switched off
			lcdc        <= 8'h00;
			stat        <= 8'h00;
			scy         <= 8'h00;
			scx         <= 8'h00;
			lyc         <= 8'h00;
			// palette default maps colours 1..3 to darker shades
			bgp         <= 8'hfc;
			lyc_written <= 1'b0;
		end else begin
			lyc_written <= 1'b0;
			if (cpu_sel && cpu_wr) begin
				case (addr)
					REG_LCDC: lcdc <= cpu_di;
					// only the interrupt enables are writable
					REG_STAT: stat <= {1'b0, cpu_di[6:3], 3'b000};
					REG_SCY:  scy <= cpu_di;
					REG_SCX:  scx <= cpu_di;
					REG_LYC: begin
						lyc         <= cpu_di;
						lyc_written <= 1'b1;
					end
					REG_BGP:  bgp <= cpu_di;
					// LY follows the line counter and ignores writes
					default: ;
				endcase
			end
		end
	end

	// ----------------------------------------------------------
	// read side
	// ----------------------------------------------------------
	always_comb begin
		case (addr)
			REG_LCDC: cpu_do = lcdc;
			// bit 7 always reads as one
			REG_STAT: cpu_do = {1'b1, stat[6:3], lyc_match, mode};
			REG_SCY:  cpu_do = scy;
			REG_SCX:  cpu_do = scx;
			REG_LY:   cpu_do = tim.v_cnt;
			REG_LYC:  cpu_do = lyc;
			REG_BGP:  cpu_do = bgp;
			// open bus
			default:  cpu_do = 8'hff;
		endcase
	end

	// fan out to the fetcher and mode machine
	assign regs.lcdc        = lcdc;
	assign regs.stat        = stat;
	assign regs.scx         = scx;
	assign regs.scy         = scy;
	assign regs.lyc         = lyc;
	assign regs.bgp         = bgp;
	assign regs.lyc_written = lyc_written;

	// master display enable
	assign lcd_on = lcdc[7];

endmodule

// File: src/lcd_timer.sv
`timescale 1ns/1ps

// horizontal and vertical position counters
module lcd_timer import video_pkg::*; (
	input  logic clk_reg,
	input  logic reset,
	input  logic lcd_on,
	lcd_timing_if.timer tim
);

	logic [8:0] h_cnt;
	logic [7:0] v_cnt;

	// last cycle of the current line
	wire last_cycle = (h_cnt == LINE_CYCLES - 9'd1);
	// last line of the frame
	wire last_line = (v_cnt == FRAME_LINES - 8'd1);

	always_ff @(posedge clk_reg) begin
		if (reset || !lcd_on) begin
			// display off parks both counters at the top left
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (last_cycle) begin
			h_cnt <= '0;
			// wrap to line 0 after the last vblank line
			if (last_line)
				v_cnt <= '0;
			else
				v_cnt <= v_cnt + 8'd1;
		end else begin
			h_cnt <= h_cnt + 9'd1;
		end
	end

	assign tim.h_cnt = h_cnt;
	assign tim.v_cnt = v_cnt;

	// strobes stay quiet while the counters are parked
	assign tim.line_end  = lcd_on && last_cycle;
	assign tim.frame_end = lcd_on && last_cycle && last_line;

endmodule

// File: src/video_top.sv
`timescale 1ns/1ps

// background video path top level
module video_top import video_pkg::*; (
	input  logic clk_reg,
	input  logic reset,

	// cpu register bus
	input  logic cpu_sel,
	input  logic [7:0] cpu_addr,
	input  logic cpu_wr,
	input  logic [7:0] cpu_di,
	output logic [7:0] cpu_do,

	// lcd side
	output logic lcd_on,
	output logic lcd_clkena,
	output logic [1:0] lcd_data,
	output logic irq,
	output logic vblank_irq,
	output logic [1:0] mode,

	// video ram
	output logic vram_rd,
	output logic [12:0] vram_addr,
	input  logic [7:0] vram_data
);

	lcd_timing_if tim_if ();
	lcd_regs_if regs_if ();

	lcd_mode_e lcd_mode;

	assign mode = lcd_mode;

	lcd_timer u_timer (
		.clk_reg (clk_reg),
		.reset   (reset),
		.lcd_on  (lcd_on),
		.tim     (tim_if.timer)
	);

	lcd_mode_fsm u_mode (
		.clk_reg    (clk_reg),
		.reset      (reset),
		.lcd_on     (lcd_on),
		.tim        (tim_if.consumer),
		.regs       (regs_if.user),
		.mode       (lcd_mode),
		.irq        (irq),
		.vblank_irq (vblank_irq)
	);

	lcd_regs u_regs (
		.clk_reg  (clk_reg),
		.reset    (reset),
		.cpu_sel  (cpu_sel),
		.cpu_addr (cpu_addr),
		.cpu_wr   (cpu_wr),
		.cpu_di   (cpu_di),
		.cpu_do   (cpu_do),
		.tim      (tim_if.consumer),
		.mode     (lcd_mode),
		.regs     (regs_if.regs),
		.lcd_on   (lcd_on)
	);

	bg_fetcher u_fetch (
		.clk_reg    (clk_reg),
		.reset      (reset),
		.tim        (tim_if.consumer),
		.regs       (regs_if.user),
		.mode       (lcd_mode),
		.vram_rd    (vram_rd),
		.vram_addr  (vram_addr),
		.vram_data  (vram_data),
		.lcd_clkena (lcd_clkena),
		.lcd_data   (lcd_data)
	);

endmodule

// File: tb/video_sva.sv
`timescale 1ns/1ps

// mode and interrupt properties on the video top level
module video_sva import video_pkg::*; (
	input logic clk_reg,
	input logic reset,
	input logic [1:0] mode,
	input logic irq,
	input logic vblank_irq,
	input logic lcd_clkena
);

	// vblank hands over to oam search, never straight to draw
	vbl_no_draw: assert property (@(posedge clk_reg) disable iff (reset)
		(mode == MODE_VBLANK) |=> (mode != MODE_DRAW))
		else $error("mode went from vblank directly to draw");

	// interrupt strobes last a single cycle
	irq_single: assert property (@(posedge clk_reg) disable iff (reset)
		irq |=> !irq)
		else $error("irq stayed high for two cycles");

	vblank_single: assert property (@(posedge clk_reg) disable iff (reset)
		vblank_irq |=> !vblank_irq)
		else $error("vblank_irq stayed high for two cycles");

	// pixels only leave while drawing
	pix_in_draw: assert property (@(posedge clk_reg) disable iff (reset)
		lcd_clkena |-> (mode == MODE_DRAW))
		else $error("lcd_clkena high outside draw");

endmodule

bind video_top video_sva u_sva (
	.clk_reg    (clk_reg),
	.reset      (reset),
	.mode       (mode),
	.irq        (irq),
	.vblank_irq (vblank_irq),
	.lcd_clkena (lcd_clkena)
);

// File: tb/video_tb.sv
`timescale 1ns/1ps

module video_tb;

	// one full frame of dot clocks
	localparam int FRAME_CYC = 456 * 154;
	localparam int ROWS = 6;

	logic clk_reg;
	logic reset;
	logic cpu_sel;
	logic [7:0] cpu_addr;
	logic cpu_wr;
	logic [7:0] cpu_di;
	logic [7:0] cpu_do;
	logic lcd_on;
	logic lcd_clkena;
	logic [1:0] lcd_data;
	logic irq;
	logic vblank_irq;
	logic [1:0] mode;
	logic vram_rd;
	logic [12:0] vram_addr;
	logic [7:0] vram_data;

	// video ram model and one captured frame
	logic [7:0] vram [0:8191];
	logic [1:0] pix [0:144*160-1];
	logic vram_hit;
	logic [7:0] vram_q;

	int value_errs;
	int other_errs;

	// ------------------------------------------------------------
	// stimulus table, one frame per row
	// ------------------------------------------------------------
	string tab_name [0:ROWS-1] = '{"map0_unsigned", "fine_scroll", "map1_signed",
		"map1_wrap", "map0_signed", "bg_disabled"};
	logic [7:0] tab_lcdc [0:ROWS-1] = '{8'h91, 8'h91, 8'h89, 8'h99, 8'h81, 8'h90};
	logic [7:0] tab_scx [0:ROWS-1] = '{8'h00, 8'h03, 8'h2d, 8'hfb, 8'h07, 8'h11};
	logic [7:0] tab_scy [0:ROWS-1] = '{8'h00, 8'h05, 8'h77, 8'hf0, 8'h90, 8'h22};
	logic [7:0] tab_bgp [0:ROWS-1] = '{8'he4, 8'he4, 8'h1b, 8'h93, 8'h6c, 8'he4};

	video_top dut (
		.clk_reg    (clk_reg),
		.reset      (reset),
		.cpu_sel    (cpu_sel),
		.cpu_addr   (cpu_addr),
		.cpu_wr     (cpu_wr),
		.cpu_di     (cpu_di),
		.cpu_do     (cpu_do),
		.lcd_on     (lcd_on),
		.lcd_clkena (lcd_clkena),
		.lcd_data   (lcd_data),
		.irq        (irq),
		.vblank_irq (vblank_irq),
		.mode       (mode),
		.vram_rd    (vram_rd),
		.vram_addr  (vram_addr),
		.vram_data  (vram_data)
	);

	initial begin
		clk_reg = 1'b0;
		forever #2 clk_reg = ~clk_reg;
	end

	// request seen at the edge, data shows up in the following cycle
	always @(posedge clk_reg) begin
		vram_hit = vram_rd;
		vram_q = vram[vram_addr];
		#1;
		if (vram_hit)
			vram_data = vram_q;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// expected shade of screen pixel x on line y
	function automatic logic [1:0] ref_shade(input logic [7:0] lcdc, input logic [7:0] scx,
		input logic [7:0] scy, input logic [7:0] bgp, input int x, input int y);
		int bx;
		int by;
		int map;
		int idx;
		int row;
		int col;
		logic [7:0] lo;
		logic [7:0] hi;
		bx = (x + int'(scx)) % 256;
		by = (y + int'(scy)) % 256;
		map = lcdc[3] ? 'h1c00 : 'h1800;
		idx = int'(vram[map + (by / 8) * 32 + bx / 8]);
		// signed tile numbers sit around 1000h
		if (lcdc[4])
			row = idx * 16 + (by % 8) * 2;
		else
			row = 'h1000 + ((idx < 128) ? idx : idx - 256) * 16 + (by % 8) * 2;
		lo = vram[row];
		hi = vram[row + 1];
		col = int'(hi[7 - bx % 8]) * 2 + int'(lo[7 - bx % 8]);
		if (!lcdc[0])
			return 2'd0;
		return bgp[2 * col +: 2];
	endfunction

	// ------------------------------------------------------------
	// cpu bus helpers
	// ------------------------------------------------------------
	task automatic reg_write(input logic [7:0] a, input logic [7:0] d);
		@(posedge clk_reg);
		#1;
		cpu_sel = 1'b1;
		cpu_wr = 1'b1;
		cpu_addr = a;
		cpu_di = d;
		@(posedge clk_reg);
		#1;
		cpu_sel = 1'b0;
		cpu_wr = 1'b0;
	endtask

	// address stays on the bus afterwards
	task automatic reg_read(input logic [7:0] a, output logic [7:0] d);
		@(posedge clk_reg);
		#1;
		cpu_sel = 1'b1;
		cpu_wr = 1'b0;
		cpu_addr = a;
		@(negedge clk_reg);
		d = cpu_do;
	endtask

	task automatic read_check(input logic [7:0] a, input logic [7:0] exp, input string name);
		logic [7:0] d;
		reg_read(a, d);
		if (d !== exp) begin
			$display("[ERROR] %s: expected %02h, actual %02h", name, exp, d);
			value_errs++;
		end
	endtask

	// single output bit against its expected level
	task automatic level_check(input logic act, input logic exp, input string name);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
			value_errs++;
		end
	endtask

	// counts pixels seen before the vblank pulse
	task automatic wait_vblank(output int pulses);
		int n;
		bit seen;
		n = 0;
		seen = 1'b0;
		pulses = 0;
		while (!seen && n < 2 * FRAME_CYC) begin
			@(negedge clk_reg);
			n++;
			if (lcd_clkena)
				pulses++;
			if (vblank_irq)
				seen = 1'b1;
		end
		if (!seen) begin
			$display("timed out waiting for the vblank interrupt");
			other_errs++;
		end
	endtask

	task automatic capture_frame(input string name);
		int n;
		int x;
		int y;
		int vbl;
		bit in_draw;
		for (n = 0; n < 144 * 160; n++)
			pix[n] = 2'bxx;
		n = 0;
		x = 0;
		y = 0;
		vbl = 0;
		in_draw = 1'b0;
		while (y < 144 && n < 2 * FRAME_CYC) begin
			@(negedge clk_reg);
			n++;
			if (vblank_irq)
				vbl++;
			if (lcd_clkena) begin
				pix[y * 160 + x] = lcd_data;
				x++;
				// line count moves on at the 160th pixel
				if (x == 160) begin
					x = 0;
					y++;
				end
			end
			// draw must close exactly on a full line
			if (in_draw && mode != 2'd3 && x != 0) begin
				$display("line %0d of %s ended after %0d pixels instead of 160", y, name, x);
				other_errs++;
			end
			in_draw = (mode == 2'd3);
		end
		if (y < 144) begin
			$display("timed out capturing %s after %0d lines", name, y);
			other_errs++;
		end
		if (vbl != 0) begin
			$display("[ERROR] %s vblank_irq in frame: expected 0, actual %0d", name, vbl);
			value_errs++;
		end
	endtask

	task automatic compare_frame(input int r);
		int x;
		int y;
		logic [1:0] exp;
		for (y = 0; y < 144; y++) begin
			for (x = 0; x < 160; x++) begin
				exp = ref_shade(tab_lcdc[r], tab_scx[r], tab_scy[r], tab_bgp[r], x, y);
				if (pix[y * 160 + x] !== exp) begin
					$display("[ERROR] %s pixel (%0d,%0d): expected %0d, actual %0d",
						tab_name[r], x, y, exp, pix[y * 160 + x]);
					value_errs++;
				end
			end
		end
	endtask

	// one frame of cycles, LY checked on each irq when asked
	task automatic watch_frame(input string name, input bit ly_check, input logic [7:0] ly_exp,
		output int irqs, output int pixels, output int reads);
		int n;
		irqs = 0;
		pixels = 0;
		reads = 0;
		for (n = 0; n < FRAME_CYC; n++) begin
			@(negedge clk_reg);
			if (irq) begin
				irqs++;
				if (ly_check && cpu_do !== ly_exp) begin
					$display("[ERROR] %s LY at irq: expected %0d, actual %0d",
						name, ly_exp, cpu_do);
					value_errs++;
				end
			end
			if (lcd_clkena)
				pixels++;
			if (vram_rd)
				reads++;
		end
	endtask

	initial begin
		int i;
		int r;
		int pulses;
		int irqs;
		int pixels;
		int reads;
		logic [31:0] seed;
		logic [7:0] d;
		reset = 1'b1;
		cpu_sel = 1'b0;
		cpu_addr = 8'h00;
		cpu_wr = 1'b0;
		cpu_di = 8'h00;
		vram_data = 8'h00;
		value_errs = 0;
		other_errs = 0;
		seed = 32'hb199b83c;
		for (i = 0; i < 8192; i++) begin
			seed = xorshift(seed);
			vram[i] = seed[7:0] ^ seed[23:16];
		end
		repeat (10) @(posedge clk_reg);
		#1;
		reset = 1'b0;

		// ------------------------------------------------------------
		// register file with the display still off
		// ------------------------------------------------------------
		read_check(8'h40, 8'h00, "reset_lcdc");
		read_check(8'h47, 8'hfc, "reset_bgp");
		// outputs quiet out of reset
		level_check(lcd_on, 1'b0, "reset_lcd_on");
		level_check(irq, 1'b0, "reset_irq");
		level_check(vblank_irq, 1'b0, "reset_vblank_irq");
		level_check(lcd_clkena, 1'b0, "reset_lcd_clkena");
		level_check(vram_rd, 1'b0, "reset_vram_rd");
		reg_write(8'h43, 8'h5a);
		read_check(8'h43, 8'h5a, "scx_readback");
		reg_write(8'h42, 8'h3c);
		read_check(8'h42, 8'h3c, "scy_readback");
		reg_write(8'h45, 8'h12);
		read_check(8'h45, 8'h12, "lyc_readback");
		reg_write(8'h47, 8'he4);
		read_check(8'h47, 8'he4, "bgp_readback");
		reg_write(8'h41, 8'h78);
		read_check(8'h41, 8'hf8, "stat_readback");
		read_check(8'h46, 8'hff, "unmapped_read");
		reg_write(8'h44, 8'h33);
		read_check(8'h44, 8'h00, "ly_read_only");
		reg_write(8'h41, 8'h00);
		read_check(8'h41, 8'h80, "stat_bit7");
		reg_write(8'h40, 8'h91);
		level_check(lcd_on, 1'b1, "lcd_on_set");

		// background frames from the table
		for (r = 0; r < ROWS; r++) begin
			wait_vblank(pulses);
			// first wait starts mid frame, later ones follow line 143
			if (r > 0 && pulses != 0) begin
				$display("[ERROR] %s pixels after line 143: expected 0, actual %0d",
					tab_name[r - 1], pulses);
				value_errs++;
			end
			reg_read(8'h44, d);
			if (d < 8'd144) begin
				$display("[ERROR] %s vblank LY: expected >= 144, actual %0d", tab_name[r], d);
				value_errs++;
			end
			reg_write(8'h40, tab_lcdc[r]);
			reg_write(8'h43, tab_scx[r]);
			reg_write(8'h42, tab_scy[r]);
			reg_write(8'h47, tab_bgp[r]);
			capture_frame(tab_name[r]);
			compare_frame(r);
		end

		// ------------------------------------------------------------
		// STAT interrupt sources
		// ------------------------------------------------------------
		wait_vblank(pulses);
		// tail of the last table frame
		if (pulses != 0) begin
			$display("[ERROR] %s pixels after line 143: expected 0, actual %0d",
				tab_name[ROWS - 1], pulses);
			value_errs++;
		end
		reg_write(8'h41, 8'h40);
		reg_write(8'h45, 8'd50);
		reg_read(8'h44, d);
		watch_frame("stat_lyc", 1'b1, 8'd50, irqs, pixels, reads);
		if (irqs != 1) begin
			$display("[ERROR] stat_lyc irq count: expected 1, actual %0d", irqs);
			value_errs++;
		end
		reg_write(8'h41, 8'h10);
		reg_read(8'h44, d);
		watch_frame("stat_vblank", 1'b0, 8'd0, irqs, pixels, reads);
		if (irqs != 1) begin
			$display("[ERROR] stat_vblank irq count: expected 1, actual %0d", irqs);
			value_errs++;
		end

		// display switched off
		wait_vblank(pulses);
		reg_write(8'h40, 8'h11);
		watch_frame("lcd_off", 1'b0, 8'd0, irqs, pixels, reads);
		level_check(lcd_on, 1'b0, "lcd_off_lcd_on");
		if (pixels != 0) begin
			$display("[ERROR] lcd_off pixels: expected 0, actual %0d", pixels);
			value_errs++;
		end
		if (reads != 0) begin
			$display("[ERROR] lcd_off vram reads: expected 0, actual %0d", reads);
			value_errs++;
		end
		read_check(8'h44, 8'h00, "lcd_off_ly");
		reg_read(8'h41, d);
		if (d[1:0] !== 2'b00) begin
			$display("[ERROR] lcd_off_stat_mode: expected 0, actual %0d", d[1:0]);
			value_errs++;
		end

		$display("checks done: %0d value errors, %0d other errors", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: video.f
common/video_pkg.sv
common/lcd_timing_if.sv
common/lcd_regs_if.sv
src/lcd_timer.sv
src/lcd_mode_fsm.sv
src/lcd_regs.sv
bg_fetcher/bg_fetcher.sv
src/video_top.sv
tb/video_sva.sv
tb/video_tb.sv
